//--- filelist.f
+incdir+source
source/ines_pkg.sv
source/load_pkg.sv
source/load_ctrl.sv
source/ines_header.sv
source/load_addr_gen.sv
source/reset_hold.sv
source/rom_loader_top.sv
sim/tb_clock.sv
sim/rom_loader_tb.sv

//--- Makefile
TOP = rom_loader_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- sim/rom_loader_tb.sv
/*
 * Testbench for the cartridge download front end: image stimulus,
 * flag word reference, memory write checker and watchdog
 */

`include "loader_consts.svh"

module rom_loader_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 100;
	localparam int MAX_GAP     = 3; // Idle cycles between bytes, at most
	localparam int PRG_PAGE    = 1 << `PRG_PAGE_SHIFT;
	localparam int CHR_PAGE    = 1 << `CHR_PAGE_SHIFT;
	localparam int JUNK_BYTES  = 64; // Payload sent after a bad header
	localparam int TOTAL_BYTES = 4 * `INES_HDR_BYTES + 3 * PRG_PAGE + CHR_PAGE + 2 * JUNK_BYTES;
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * (MAX_GAP + 2) + 8 * (`LOAD_HOLD_CYCLES + 20);

	logic              clk;
	logic              reset;
	logic              download;
	logic              byte_valid;
	logic [7:0]        byte_data;
	logic              invert_mirroring;
	logic [21:0]       mem_addr;
	logic [7:0]        mem_data;
	logic              mem_write;
	logic [31:0]       mapper_flags;
	logic              done;
	logic              error;
	logic              core_reset;
	int                seed;
	int                value_errors;
	int                other_errors;
	logic [21:0]       exp_addr_q[$]; // Addresses still to be written
	logic [15:0][7:0]  hdr;

	tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	rom_loader_top i_rom_loader_top (
		.clk              (clk),
		.reset            (reset),
		.download         (download),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.done             (done),
		.error            (error),
		.core_reset       (core_reset)
	);

	// Fill pattern over all 22 address bits
	function automatic logic [7:0] payload_byte(input logic [21:0] addr);
		return addr[7:0] ^ addr[15:8] ^ {2'b00, addr[21:16]} ^ 8'hA5;
	endfunction

	// Doubling size class, 7 for anything above 64 pages
	function automatic logic [2:0] size_class(input int pages);
		int code;
		int limit;
		code  = 0;
		limit = 1;
		while (pages > limit && code < 7) begin
			code  = code + 1;
			limit = limit * 2;
		end
		return 3'(code);
	endfunction

	function automatic logic [31:0] flags_ref(input logic [15:0][7:0] h, input logic inv);
		logic        dirty;
		logic [31:0] flags;
		dirty         = (h[7][3:2] != 2'b10) && (h[15:8] != '0);
		flags         = '0;
		flags[3:0]    = h[6][7:4];
		flags[7:4]    = dirty ? 4'h0 : h[7][7:4];
		flags[10:8]   = size_class(int'(h[4]));
		flags[13:11]  = size_class(int'(h[5]));
		flags[14]     = h[6][0] ^ inv;
		flags[15]     = (h[5] == 8'd0); // CHR-RAM
		flags[16]     = h[6][3];
		return flags;
	endfunction

	function automatic logic [15:0][7:0] make_header(input logic [7:0] prg, input logic [7:0] chr,
		input logic [7:0] b6, input logic [7:0] b7, input logic [7:0] b12);
		logic [15:0][7:0] h;
		h     = '0;
		h[0]  = 8'h4E;
		h[1]  = 8'h45;
		h[2]  = 8'h53;
		h[3]  = 8'h1A;
		h[4]  = prg;
		h[5]  = chr;
		h[6]  = b6;
		h[7]  = b7;
		h[12] = b12;
		return h;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		other_errors++;
	endtask

	// Entered and left on a falling edge
	task automatic send_byte(input logic [7:0] data);
		int gap;
		gap = $unsigned($random(seed)) % (MAX_GAP + 1);
		repeat (gap) @(negedge clk);
		byte_data  = data;
		byte_valid = 1'b1;
		@(negedge clk);
		byte_valid = 1'b0;
	endtask

	task automatic wait_done(input int limit);
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (done !== 1'b1)
			report_failure("done did not rise after the last byte");
	endtask

	task automatic load_image(input logic [15:0][7:0] h, input logic inv, input logic good);
		int          i;
		logic [21:0] addr;
		repeat (4) @(negedge clk); // Let the loader drop back to idle
		invert_mirroring = inv;
		download         = 1'b1;
		@(negedge clk);
		for (i = 0; i < `INES_HDR_BYTES; i++)
			send_byte(h[i]);
		if (good) begin
			for (i = 0; i < (int'(h[4]) << `PRG_PAGE_SHIFT); i++) begin
				addr = 22'(i);
				exp_addr_q.push_back(addr);
				send_byte(payload_byte(addr));
			end
			@(negedge clk); // Idle cycle for the switch to CHR
			for (i = 0; i < (int'(h[5]) << `CHR_PAGE_SHIFT); i++) begin
				addr = `CHR_BASE_ADDR + 22'(i);
				exp_addr_q.push_back(addr);
				send_byte(payload_byte(addr));
			end
		end else begin
			for (i = 0; i < JUNK_BYTES; i++)
				send_byte(payload_byte(22'(i)));
		end
		wait_done(8);
		if (exp_addr_q.size() != 0)
			report_failure($sformatf("%0d memory writes never happened", exp_addr_q.size()));
		exp_addr_q.delete();
		check_value("done", 32'(done), 32'd1);
		check_value("error", 32'(error), 32'(!good));
		if (good) begin
			repeat (2) @(negedge clk); // Flag word latches a cycle after done
			check_value("mapper_flags", mapper_flags, flags_ref(h, inv));
		end
	endtask

	// core_reset must fall on the hold-th edge with download low
	task automatic check_hold_release;
		int k;
		download = 1'b0;
		for (k = 1; k <= `LOAD_HOLD_CYCLES; k++) begin
			@(negedge clk);
			check_value("core_reset", 32'(core_reset), 32'(k < `LOAD_HOLD_CYCLES));
		end
	endtask

	task automatic check_error_hold;
		download = 1'b0;
		repeat (`LOAD_HOLD_CYCLES + 4) @(negedge clk);
		check_value("core_reset", 32'(core_reset), 32'd1);
		check_value("error", 32'(error), 32'd1);
		check_value("done", 32'(done), 32'd1);
	endtask

	// Every write is matched against the address the driver expects next
	always @(posedge clk) begin : compare_writes
		logic [21:0] exp_addr;
		if (mem_write === 1'b1) begin
			if (exp_addr_q.size() == 0) begin
				report_failure($sformatf("unexpected memory write to address %h", mem_addr));
			end else begin
				exp_addr = exp_addr_q.pop_front();
				check_value("mem_addr", 32'(mem_addr), 32'(exp_addr));
				check_value("mem_data", 32'(mem_data), 32'(payload_byte(exp_addr)));
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		seed             = 32'h38fb_ce55;
		value_errors     = 0;
		other_errors     = 0;
		download         = 1'b0;
		byte_valid       = 1'b0;
		byte_data        = 8'h00;
		invert_mirroring = 1'b0;
		hdr              = '0;
		wait (reset === 1'b0);
		byte_valid = 1'b1; // Stray strobe with no download running
		@(negedge clk);
		check_value("done", 32'(done), 32'd0);
		check_value("error", 32'(error), 32'd0);
		check_value("mem_write", 32'(mem_write), 32'd0);
		byte_valid = 1'b0;
		repeat (10) begin
			check_value("core_reset", 32'(core_reset), 32'd1); // Power-on hold
			@(negedge clk);
		end

		// Mapper 4, one PRG and one CHR page, mirroring inverted
		hdr = make_header(8'd1, 8'd1, 8'h41, 8'h00, 8'h00);
		load_image(hdr, 1'b1, 1'b1);
		check_hold_release();

		// Dirty tail in byte 12, CHR-RAM, four-screen
		hdr = make_header(8'd2, 8'd0, 8'h28, 8'h50, 8'h44);
		load_image(hdr, 1'b0, 1'b1);
		check_value("mapper_flags[7:4]", 32'(mapper_flags[7:4]), 32'd0);
		check_value("mapper_flags[15]", 32'(mapper_flags[15]), 32'd1);
		check_hold_release();

		hdr    = make_header(8'd1, 8'd1, 8'h41, 8'h00, 8'h00);
		hdr[3] = 8'h1B; // Broken magic
		load_image(hdr, 1'b0, 1'b0);
		check_error_hold();

		hdr    = make_header(8'd1, 8'd1, 8'h41, 8'h00, 8'h00);
		hdr[6] = 8'h45; // Trainer present
		load_image(hdr, 1'b0, 1'b0);
		check_error_hold();

		repeat (4) @(negedge clk);
		$display("Checks done: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- sim/tb_clock.sv
/*
 * Testbench clock and synchronous reset source
 */

module tb_clock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk); // Release between active edges
		reset = 1'b0;
	end

endmodule

//--- source/rom_loader_top.sv
/*
 * Cartridge download front end: ties the hold logic, control FSM,
 * header decoder and address generator together, latches the flag word
 */

module rom_loader_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    download,
	input  logic                    byte_valid,
	input  ines_pkg::ines_byte_t    byte_data,
	input  logic                    invert_mirroring,
	output load_pkg::mem_addr_t     mem_addr,
	output load_pkg::mem_data_t     mem_data,
	output logic                    mem_write,
	output ines_pkg::mapper_flags_t mapper_flags,
	output logic                    done,
	output logic                    error,
	output logic                    core_reset
);
	import ines_pkg::*;
	import load_pkg::*;

	logic          loader_enable;
	logic          hold_active;
	load_state_t   state;
	logic [3:0]    hdr_index;
	logic          load_prg;
	logic          load_chr;
	logic          header_ok;
	logic          bytes_left_zero;
	page_count_t   prg_pages;
	page_count_t   chr_pages;
	mapper_flags_t hdr_flags; // Live decode, settles once the header is in
	logic          done_q;

	reset_hold i_reset_hold (
		.clk           (clk),
		.reset         (reset),
		.download      (download),
		.loader_enable (loader_enable),
		.hold_active   (hold_active)
	);

	load_ctrl i_load_ctrl (
		.clk             (clk),
		.reset           (reset),
		.loader_enable   (loader_enable),
		.byte_valid      (byte_valid),
		.header_ok       (header_ok),
		.bytes_left_zero (bytes_left_zero),
		.state           (state),
		.hdr_index       (hdr_index),
		.load_prg        (load_prg),
		.load_chr        (load_chr),
		.mem_write       (mem_write),
		.done            (done),
		.error           (error)
	);

	ines_header i_ines_header (
		.clk              (clk),
		.reset            (reset),
		.loader_enable    (loader_enable),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.hdr_index        (hdr_index),
		.state            (state),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.mapper_flags     (hdr_flags)
	);

	load_addr_gen i_load_addr_gen (
		.clk             (clk),
		.reset           (reset),
		.loader_enable   (loader_enable),
		.load_prg        (load_prg),
		.load_chr        (load_chr),
		.prg_pages       (prg_pages),
		.chr_pages       (chr_pages),
		.mem_write       (mem_write),
		.mem_addr        (mem_addr),
		.bytes_left_zero (bytes_left_zero)
	);

	assign mem_data = byte_data; // Bytes go straight to memory

	always_ff @(posedge clk) begin
		if (reset)
			done_q <= 1'b0;
		else
			done_q <= done;
	end

	// Flag word is captured once per image on the rising edge of done
	always_ff @(posedge clk) begin
		if (done && !done_q)
			mapper_flags <= hdr_flags;
	end

	assign core_reset = hold_active || error;

endmodule

//--- source/reset_hold.sv
/*
 * Power-on hold, post-download hold counter and loader enable
 */

`include "loader_consts.svh"

module reset_hold (
	input  logic clk,
	input  logic reset,
	input  logic download,
	output logic loader_enable,
	output logic hold_active
);
	localparam int HOLD_W = $clog2(`LOAD_HOLD_CYCLES + 1);

	logic              power_on; // Until the first download starts
	logic [HOLD_W-1:0] hold_cnt;

	always_ff @(posedge clk) begin
		if (reset)
			power_on <= 1'b1;
		else if (download)
			power_on <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset)
			hold_cnt <= '0;
		else if (download)
			hold_cnt <= HOLD_W'(`LOAD_HOLD_CYCLES);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1; // First tick on the first low edge
	end

	assign loader_enable = download || (hold_cnt != '0);
	assign hold_active   = power_on || loader_enable;

endmodule

//--- source/load_addr_gen.sv
/*
 * Remaining-byte counter and write address for the PRG and CHR regions
 */

`include "loader_consts.svh"

module load_addr_gen (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  loader_enable,
	input  logic                  load_prg,
	input  logic                  load_chr,
	input  ines_pkg::page_count_t prg_pages,
	input  ines_pkg::page_count_t chr_pages,
	input  logic                  mem_write,
	output load_pkg::mem_addr_t   mem_addr,
	output logic                  bytes_left_zero
);
	import ines_pkg::*;
	import load_pkg::*;

	byte_count_t bytes_left;

	always_ff @(posedge clk) begin
		if (reset || !loader_enable) begin
			bytes_left <= '0;
			mem_addr   <= '0;
		end else if (load_prg) begin
			bytes_left <= byte_count_t'(prg_pages) << `PRG_PAGE_SHIFT;
			mem_addr   <= '0; // PRG starts at the bottom
		end else if (load_chr) begin
			bytes_left <= byte_count_t'(chr_pages) << `CHR_PAGE_SHIFT;
			mem_addr   <= `CHR_BASE_ADDR;
		end else if (mem_write) begin
			bytes_left <= bytes_left - 22'd1;
			mem_addr   <= mem_addr + 22'd1;
		end
	end

	assign bytes_left_zero = (bytes_left == '0);

	// The controller must stop writing once the region is full
	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		mem_write |-> (bytes_left != '0));

endmodule

//--- source/ines_header.sv
/*
 * iNES header store, magic and trainer check,
 * size class and dirty-header decode into the mapper flag word
 */

`include "loader_consts.svh"

module ines_header (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   loader_enable,
	input  logic                   byte_valid,
	input  ines_pkg::ines_byte_t   byte_data,
	input  logic [3:0]             hdr_index,
	input  load_pkg::load_state_t  state,
	input  logic                   invert_mirroring,
	output logic                   header_ok,
	output ines_pkg::page_count_t  prg_pages,
	output ines_pkg::page_count_t  chr_pages,
	output ines_pkg::mapper_flags_t mapper_flags
);
	import ines_pkg::*;
	import load_pkg::*;

	// Bytes 0..7 hold every field, 8..15 only matter as zero or not
	localparam int FIELD_BYTES = `INES_HDR_BYTES / 2;

	ines_byte_t  hdr [0:FIELD_BYTES-1];
	logic        hdr_strobe;
	logic        tail_nonzero; // Any of bytes 8..15 nonzero
	logic        is_nes20;
	logic        is_dirty;
	logic        chr_ram;
	size_code_t  prg_size;
	size_code_t  chr_size;
	mapper_num_t mapper;

	function automatic size_code_t size_code(input page_count_t pages);
		if (pages <= 8'd1)       return 3'd0;
		else if (pages <= 8'd2)  return 3'd1;
		else if (pages <= 8'd4)  return 3'd2;
		else if (pages <= 8'd8)  return 3'd3;
		else if (pages <= 8'd16) return 3'd4;
		else if (pages <= 8'd32) return 3'd5;
		else if (pages <= 8'd64) return 3'd6;
		else                     return 3'd7;
	endfunction

	assign hdr_strobe = loader_enable && byte_valid && (state == ST_HEADER);

	always_ff @(posedge clk) begin
		if (hdr_strobe && !hdr_index[3])
			hdr[hdr_index[2:0]] <= byte_data;
	end

	always_ff @(posedge clk) begin
		if (reset || !loader_enable) begin
			tail_nonzero <= 1'b0;
		end else if (hdr_strobe) begin
			if (hdr_index == 4'd0)
				tail_nonzero <= 1'b0; // Fresh header
			else if (hdr_index[3] && (byte_data != 8'h00))
				tail_nonzero <= 1'b1;
		end
	end

	// "NES" + EOF, and no trainer support
	assign header_ok = (hdr[0] == 8'h4E) && (hdr[1] == 8'h45) && (hdr[2] == 8'h53) &&
		(hdr[3] == 8'h1A) && !hdr[6][2];

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];

	assign is_nes20 = (hdr[7][3:2] == 2'b10);
	assign is_dirty = !is_nes20 && tail_nonzero; // Junk text in old dumps
	assign chr_ram  = (chr_pages == 8'd0);
	assign prg_size = size_code(prg_pages);
	assign chr_size = size_code(chr_pages);
	assign mapper   = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};

	assign mapper_flags = {15'd0, hdr[6][3], chr_ram, hdr[6][0] ^ invert_mirroring,
		chr_size, prg_size, mapper};

endmodule

//--- source/load_ctrl.sv
/*
 * Loader control FSM: counts header bytes, then sequences
 * PRG and CHR writes and ends in DONE or ERROR
 */

`include "loader_consts.svh"

module load_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 loader_enable,
	input  logic                 byte_valid,
	input  logic                 header_ok,
	input  logic                 bytes_left_zero,
	output load_pkg::load_state_t state,
	output logic [3:0]           hdr_index,
	output logic                 load_prg,
	output logic                 load_chr,
	output logic                 mem_write,
	output logic                 done,
	output logic                 error
);
	import load_pkg::*;

	logic hdr_last;

	assign hdr_last = (hdr_index == 4'(`INES_HDR_BYTES - 1));

	// Counter and base address load on the edge that leaves HEADER
	assign load_prg = loader_enable && (state == ST_HEADER) && byte_valid && hdr_last &&
		header_ok;

	// Idle cycle after the last PRG byte
	assign load_chr = loader_enable && (state == ST_PRG) && bytes_left_zero;

	// Zero-latency write strobe, one per payload byte
	assign mem_write = byte_valid && !bytes_left_zero &&
		((state == ST_PRG) || (state == ST_CHR));

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_HEADER;
			hdr_index <= '0;
			done      <= 1'b0;
			error     <= 1'b0;
		end else if (!loader_enable) begin
			// Back to idle, a header error stays visible
			state     <= ST_HEADER;
			hdr_index <= '0;
			done      <= error;
		end else begin
			case (state)
			ST_HEADER: begin
				if (byte_valid) begin
					hdr_index <= hdr_index + 4'd1; // Wraps to 0 on the last byte
					if (hdr_index == 4'd0) begin
						done  <= 1'b0; // New image starts
						error <= 1'b0;
					end
					if (hdr_last) begin
						if (header_ok) begin
							state <= ST_PRG;
						end else begin
							state <= ST_ERROR;
							done  <= 1'b1;
							error <= 1'b1;
						end
					end
				end
			end
			ST_PRG: begin
				if (bytes_left_zero)
					state <= ST_CHR;
			end
			ST_CHR: begin
				if (bytes_left_zero) begin
					state <= ST_DONE;
					done  <= 1'b1;
				end
			end
			ST_DONE, ST_ERROR: ; // Wait for the hold time to expire
			default: state <= ST_HEADER;
			endcase
		end
	end

	// A strobe the byte counter would accept only comes in a payload phase
	a_write_phase: assert property (@(posedge clk) disable iff (reset)
		(byte_valid && !bytes_left_zero) |-> (state == ST_PRG || state == ST_CHR));

	a_error_done: assert property (@(posedge clk) disable iff (reset)
		error |-> done);

endmodule

//--- source/load_pkg.sv
/*
 * Loader state machine encoding and memory side types
 */

package load_pkg;

	typedef enum logic [2:0] {
		ST_HEADER, // Collecting the 16 header bytes
		ST_PRG,    // Writing PRG ROM
		ST_CHR,    // Writing CHR ROM
		ST_DONE,
		ST_ERROR   // Bad magic or trainer present
	} load_state_t;

	// 22-bit cartridge memory address
	typedef logic [21:0] mem_addr_t;

	// Bytes still to be written in the current region
	typedef logic [21:0] byte_count_t;

	typedef logic [7:0] mem_data_t;

endpackage

//--- source/ines_pkg.sv
/*
 * iNES header field types and the packed mapper flag word
 */

package ines_pkg;

	// One raw header byte
	typedef logic [7:0] ines_byte_t;

	// Page count from header byte 4 (PRG) or 5 (CHR)
	typedef logic [7:0] page_count_t;

	// Power-of-two size class, 0 = one page or less, 7 = above 64 pages
	typedef logic [2:0] size_code_t;

	typedef logic [7:0] mapper_num_t;

	// Flag word handed to the console core
	// 7:0 mapper, 10:8 PRG size, 13:11 CHR size, 14 mirroring,
	// 15 CHR-RAM, 16 four-screen, rest zero
	typedef logic [31:0] mapper_flags_t;

endpackage

//--- source/loader_consts.svh
/*
 * Loader constants: iNES header length, PRG and CHR page sizes,
 * CHR region base address and the reset hold time after a download
 */

`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// iNES header, fixed length
`define INES_HDR_BYTES 16

// 16 KiB PRG pages
`define PRG_PAGE_SHIFT 14

// 8 KiB CHR pages
`define CHR_PAGE_SHIFT 13

// CHR bytes go to the upper half of the 4 MiB space
`define CHR_BASE_ADDR 22'h20_0000

// Core stays in reset this many cycles after download falls
`define LOAD_HOLD_CYCLES 255

`endif
